//--- src/cmdPkg.sv
package cmdPkg;

  // Raw 16-bit command word as it arrives on the command port
  typedef logic [15:0] cmdT;

  // Motion fields
  typedef logic [7:0] headingT;
  typedef logic [3:0] squaresT;

  // Opcodes in bits 15:12
  typedef enum logic [3:0] {
    OP_CAL  = 4'h2,
    OP_MOVE = 4'h4,
    OP_HEAD = 4'h8
  } opcodeE;

  // Field layout of a command word, msb first
  typedef struct packed {
    logic [3:0] opcode;
    headingT    heading;
    squaresT    squares;
  } cmdFieldsT;

  // Operation as seen by the execute stage
  typedef enum logic [1:0] {
    K_CAL,
    K_MOVE,
    K_HEAD,
    K_BAD
  } opKindE;

endpackage

//--- src/respPkg.sv
package respPkg;

  // One response byte per command
  typedef logic [7:0] respT;

  // Positive acknowledge
  localparam respT RESP_ACK = 8'hA5;

  // Negative acknowledge, for rejected or unknown commands
  localparam respT RESP_NAK = 8'h5A;

endpackage

//--- src/knightIfs.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Decoded operation, decode stage to execute stage
////////////////////////////////////////////////////////////
interface opIf;
  import cmdPkg::*;

  logic    valid;
  logic    ready;
  opKindE  kind;
  headingT heading;
  squaresT squares;

  // Decoder side
  modport src(output valid, kind, heading, squares, input ready);

  // Execute side
  modport dst(input valid, kind, heading, squares, output ready);

endinterface

////////////////////////////////////////////////////////////
// Execution outcome, execute stage to result stage
////////////////////////////////////////////////////////////
interface doneIf;
  import cmdPkg::*;

  logic    valid;
  logic    ready;
  opKindE  kind;
  logic    ok;
  // Heading after the operation completed
  headingT heading;

  modport src(output valid, kind, ok, heading, input ready);
  modport dst(input valid, kind, ok, heading, output ready);

endinterface

//--- src/cmdQueue.sv
`timescale 1ns/1ps

module cmdQueue #(
  parameter type payloadT   = logic [7:0],
  parameter int  queueDepth = 2
) (
  input  logic    clk,
  input  logic    rst,
  input  payloadT inData,
  input  logic    inValid,
  output logic    inReady,
  output payloadT outData,
  output logic    outValid,
  input  logic    outReady
);

  // Pointer needs at least one bit even for a single entry
  localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int cntW = $clog2(queueDepth + 1);

  payloadT         mem [queueDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic            push;
  logic            pop;

  // Full when count reaches the depth
  assign inReady  = (count < cntW'(queueDepth));
  assign outValid = (count != '0);
  // Head entry, visible the cycle after it is written
  assign outData  = mem[rdPtr];

  assign push = inValid && inReady;
  assign pop  = outValid && outReady;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= inData;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      // Wrap at queueDepth, which need not be a power of two
      if (push) begin
        wrPtr <= (wrPtr == ptrW'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == ptrW'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/cmdDecode.sv
`timescale 1ns/1ps

module cmdDecode (
  input  logic        clk,
  input  logic        rst,
  input  cmdPkg::cmdT cmd,
  input  logic        cmdValid,
  output logic        cmdReady,
  opIf.src            op
);
  import cmdPkg::*;

  cmdFieldsT fields;
  opKindE    kindNext;
  logic      take;

  // Split the word into opcode, heading and square count
  assign fields = cmdFieldsT'(cmd);

  // Output register empty or being drained this cycle
  assign cmdReady = !op.valid || op.ready;
  assign take     = cmdValid && cmdReady;

  ////////////////////////////////////////////////////////////
  // Opcode classification and static checks
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (fields.opcode)
      OP_CAL:  kindNext = K_CAL;
      // A zero-square move is rejected here already
      OP_MOVE: kindNext = (fields.squares == '0) ? K_BAD : K_MOVE;
      OP_HEAD: kindNext = K_HEAD;
      default: kindNext = K_BAD;
    endcase
  end

  // Valid flag
  always_ff @(posedge clk) begin
    if (rst) begin
      op.valid <= 1'b0;
    end else if (take) begin
      op.valid <= 1'b1;
    end else if (op.ready) begin
      op.valid <= 1'b0;
    end
  end

  // Fields, loaded only on acceptance so they hold while stalled
  always_ff @(posedge clk) begin
    if (take) begin
      op.kind    <= kindNext;
      op.heading <= fields.heading;
      op.squares <= fields.squares;
    end
  end

endmodule

//--- src/motionExec.sv
`timescale 1ns/1ps

module motionExec #(
  parameter int calCycles    = 64,
  parameter int squareCycles = 16
) (
  input  logic clk,
  input  logic rst,
  opIf.dst     op,
  doneIf.src   done
);
  import cmdPkg::*;

  // Longest wait is either calibration or a 15-square move
  localparam int maxCycles = (calCycles > 15 * squareCycles) ? calCycles : 15 * squareCycles;
  localparam int cntW      = $clog2(maxCycles + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUSY,
    S_REPORT
  } stateE;

  stateE           state;
  logic [cntW-1:0] cnt;
  opKindE          kindQ;
  logic            okQ;
  headingT         pendHeading;
  headingT         heading;
  logic            calibrated;
  logic            take;

  // One operation in flight
  assign op.ready = (state == S_IDLE);
  assign take     = op.valid && op.ready;

  assign done.valid   = (state == S_REPORT);
  assign done.kind    = kindQ;
  assign done.ok      = okQ;
  assign done.heading = heading;

  ////////////////////////////////////////////////////////////
  // Control FSM and robot state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      cnt        <= '0;
      calibrated <= 1'b0;
      heading    <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (take) begin
            state <= S_BUSY;
            // Count L-1 down to 0 for a latency of L cycles
            if (op.kind == K_CAL) begin
              cnt <= cntW'(calCycles - 1);
            end else if (op.kind == K_MOVE && calibrated) begin
              cnt <= cntW'(op.squares * squareCycles - 1);
            end else begin
              cnt <= '0;
            end
          end
        end
        S_BUSY: begin
          if (cnt == '0) begin
            state <= S_REPORT;
            // Side effects land as the operation completes
            if (kindQ == K_CAL) begin
              calibrated <= 1'b1;
            end
            if (kindQ == K_MOVE && okQ) begin
              heading <= pendHeading;
            end
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        // Wait for the result stage
        S_REPORT: begin
          if (done.ready) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Operation payload captured at acceptance
  always_ff @(posedge clk) begin
    if (take) begin
      kindQ       <= op.kind;
      pendHeading <= op.heading;
      // Moves need calibration, bad ops always fail
      okQ <= (op.kind == K_MOVE) ? calibrated : (op.kind != K_BAD);
    end
  end

endmodule

//--- src/respGen.sv
`timescale 1ns/1ps

module respGen (
  input  logic          clk,
  input  logic          rst,
  doneIf.dst            done,
  output respPkg::respT resp,
  output logic          respValid,
  input  logic          respReady
);
  import cmdPkg::*;
  import respPkg::*;

  respT respNext;
  logic take;

  // Same skid rule as the decoder
  assign done.ready = !respValid || respReady;
  assign take       = done.valid && done.ready;

  ////////////////////////////////////////////////////////////
  // Outcome to response byte
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (done.kind == K_HEAD) begin
      // Heading is returned raw
      respNext = done.heading;
    end else if (done.ok) begin
      respNext = RESP_ACK;
    end else begin
      respNext = RESP_NAK;
    end
  end

  // Valid flag
  always_ff @(posedge clk) begin
    if (rst) begin
      respValid <= 1'b0;
    end else if (take) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  // Response byte, held while the queue is full
  always_ff @(posedge clk) begin
    if (take) begin
      resp <= respNext;
    end
  end

endmodule

//--- src/knightCmd.sv
`timescale 1ns/1ps

module knightCmd #(
  parameter int calCycles    = 64,
  parameter int squareCycles = 16,
  parameter int queueDepth   = 2
) (
  input  logic          clk,
  input  logic          rst,
  input  cmdPkg::cmdT   cmd,
  input  logic          cmdValid,
  output logic          cmdReady,
  output respPkg::respT resp,
  output logic          respValid,
  input  logic          respReady
);
  import cmdPkg::*;
  import respPkg::*;

  // Command queue to decoder
  cmdT  qCmd;
  logic qCmdValid;
  logic qCmdReady;

  // Result stage to response queue
  respT rspByte;
  logic rspValid;
  logic rspReady;

  opIf   opBus ();
  doneIf doneBus ();

  ////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////
  cmdQueue #(.payloadT(cmdT), .queueDepth(queueDepth)) uCmdQueue (
    .clk(clk), .rst(rst),
    .inData(cmd), .inValid(cmdValid), .inReady(cmdReady),
    .outData(qCmd), .outValid(qCmdValid), .outReady(qCmdReady)
  );

  cmdDecode uDecode (
    .clk(clk), .rst(rst),
    .cmd(qCmd), .cmdValid(qCmdValid), .cmdReady(qCmdReady),
    .op(opBus.src)
  );

  // Execute stage owns calibration and heading
  motionExec #(.calCycles(calCycles), .squareCycles(squareCycles)) uExec (
    .clk(clk), .rst(rst),
    .op(opBus.dst), .done(doneBus.src)
  );

  ////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////
  respGen uResp (
    .clk(clk), .rst(rst),
    .done(doneBus.dst),
    .resp(rspByte), .respValid(rspValid), .respReady(rspReady)
  );

  cmdQueue #(.payloadT(respT), .queueDepth(queueDepth)) uRespQueue (
    .clk(clk), .rst(rst),
    .inData(rspByte), .inValid(rspValid), .inReady(rspReady),
    .outData(resp), .outValid(respValid), .outReady(respReady)
  );

endmodule

//--- sim/knightCmdTb.sv
`timescale 1ns/1ps

module knightCmdTb;

  localparam int timeoutCycles = 20000;
  // Response codes as defined for the command port
  localparam logic [7:0] ACK = 8'hA5;
  localparam logic [7:0] NAK = 8'h5A;

  logic        clk;
  logic        rst;
  logic [15:0] cmd;
  logic        cmdValid;
  logic        cmdReady;
  logic [7:0]  resp;
  logic        respValid;
  logic        respReady;

  integer      seed;
  int          cycleCount;
  int          errCount;
  int          errAtStart;
  int          testsPassed;
  int          testsFailed;
  string       testName;
  // Reference model state and expected responses in command order
  logic        modelCal;
  logic [7:0]  modelHeading;
  logic [7:0]  expQ[$];

  knightCmd #(.calCycles(64), .squareCycles(16), .queueDepth(2)) u_dut (
    .clk(clk), .rst(rst),
    .cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
    .resp(resp), .respValid(respValid), .respReady(respReady)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit, covers the longest random moves with margin
  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: simulation timed out after %0d cycles", cycleCount);
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and bus tasks
  ////////////////////////////////////////////////////////////
  task automatic predictResp(input logic [15:0] c);
    logic [3:0] opc;
    logic [7:0] hd;
    logic [3:0] sq;
    logic [7:0] r;
    opc = c[15:12];
    hd  = c[11:4];
    sq  = c[3:0];
    case (opc)
      4'h2: begin
        modelCal = 1'b1;
        r = ACK;
      end
      // Move needs calibration and a non-zero count
      4'h4: begin
        if (modelCal && sq != 4'd0) begin
          modelHeading = hd;
          r = ACK;
        end else begin
          r = NAK;
        end
      end
      4'h8: r = modelHeading;
      default: r = NAK;
    endcase
    expQ.push_back(r);
  endtask

  // Called at posedge+2, returns at posedge+2 after the transfer
  task automatic sendCmd(input logic [15:0] c);
    logic accepted;
    predictResp(c);
    cmd = c;
    cmdValid = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = cmdReady;
      @(posedge clk);
      #2;
    end
    cmdValid = 1'b0;
  endtask

  task automatic collectResp(input int n, input bit randomReady);
    int          got;
    logic [31:0] rnd;
    logic [7:0]  expVal;
    got = 0;
    while (got < n) begin
      if (randomReady) begin
        rnd = $random(seed);
        respReady = rnd[0];
      end else begin
        respReady = 1'b1;
      end
      // Mid-cycle sample, transfer lands on the next edge
      @(negedge clk);
      if (respValid && respReady) begin
        if (expQ.size() == 0) begin
          $display("%s: a response arrived with none outstanding", testName);
          errCount++;
        end else begin
          expVal = expQ.pop_front();
          if (resp !== expVal) begin
            $display("Error %s: response %0d expected %02h actual %02h",
                     testName, got, expVal, resp);
            errCount++;
          end
        end
        got++;
      end
      @(posedge clk);
      #2;
    end
    respReady = 1'b0;
  endtask

  task automatic startTest(input string name);
    testName = name;
    errAtStart = errCount;
  endtask

  task automatic endTest();
    if (errCount == errAtStart) begin
      testsPassed++;
      $display("%s: ok", testName);
    end else begin
      testsFailed++;
      $display("%s: %0d errors", testName, errCount - errAtStart);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic checkReset();
    startTest("checkReset");
    @(negedge clk);
    if (respValid !== 1'b0) begin
      $display("Error %s: respValid expected 0 actual %b", testName, respValid);
      errCount++;
    end
    if (cmdReady !== 1'b1) begin
      $display("Error %s: cmdReady expected 1 actual %b", testName, cmdReady);
      errCount++;
    end
    @(posedge clk);
    #2;
    endTest();
  endtask

  task automatic moveUncalibrated();
    startTest("moveUncalibrated");
    sendCmd({4'h4, 8'h11, 4'd2});
    sendCmd({4'h8, 12'h000});
    collectResp(2, 1'b0);
    endTest();
  endtask

  task automatic calibrateAndMove();
    startTest("calibrateAndMove");
    sendCmd({4'h2, 12'h000});
    sendCmd({4'h4, 8'h3C, 4'd3});
    sendCmd({4'h8, 12'h000});
    collectResp(3, 1'b0);
    endTest();
  endtask

  // Bad opcode and zero-square move leave the heading alone
  task automatic rejectedOps();
    startTest("rejectedOps");
    sendCmd({4'hF, 8'h12, 4'd5});
    sendCmd({4'h4, 8'h77, 4'd0});
    sendCmd({4'h8, 12'h000});
    collectResp(3, 1'b0);
    endTest();
  endtask

  task automatic backPressure();
    int          sent;
    bit          filled;
    logic [15:0] c;
    startTest("backPressure");
    sent = 0;
    filled = 1'b0;
    respReady = 1'b0;
    // Let the pipeline settle before each look at cmdReady
    // Long enough for a calibration to reach the response queue
    while (!filled && sent < 12) begin
      repeat (80) @(posedge clk);
      #2;
      @(negedge clk);
      filled = !cmdReady;
      @(posedge clk);
      #2;
      if (!filled) begin
        case (sent % 3)
          0:       c = {4'h8, 12'h000};
          1:       c = {4'h2, 12'h000};
          default: c = {4'hF, 12'hABC};
        endcase
        sendCmd(c);
        sent++;
      end
    end
    if (!filled) begin
      $display("%s: cmdReady never went low with respReady held low", testName);
      errCount++;
    end
    collectResp(sent, 1'b0);
    endTest();
  endtask

  task automatic randomCmds();
    logic [15:0] cmds[30];
    logic [31:0] rnd;
    logic [3:0]  opc;
    startTest("randomCmds");
    for (int i = 0; i < 30; i++) begin
      rnd = $random(seed);
      case (rnd[1:0])
        2'd0:    opc = 4'h2;
        2'd1:    opc = 4'h4;
        2'd2:    opc = 4'h8;
        default: opc = 4'h0;
      endcase
      cmds[i] = {opc, rnd[15:8], rnd[7:4]};
    end
    fork
      begin
        for (int i = 0; i < 30; i++) begin
          sendCmd(cmds[i]);
        end
      end
      collectResp(30, 1'b1);
    join
    endTest();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rst = 1'b1;
    cmd = '0;
    cmdValid = 1'b0;
    respReady = 1'b0;
    seed = 32'h6d39201f;
    errCount = 0;
    errAtStart = 0;
    testsPassed = 0;
    testsFailed = 0;
    testName = "reset";
    modelCal = 1'b0;
    modelHeading = 8'h00;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    checkReset();
    moveUncalibrated();
    calibrateAndMove();
    rejectedOps();
    backPressure();
    randomCmds();
    $display("Tests passed: %0d, failed: %0d, errors: %0d", testsPassed, testsFailed, errCount);
    if (testsFailed == 0 && expQ.size() == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
src/cmdPkg.sv
src/respPkg.sv
src/knightIfs.sv
src/cmdQueue.sv
src/cmdDecode.sv
src/motionExec.sv
src/respGen.sv
src/knightCmd.sv
sim/knightCmdTb.sv

//--- run.sh
#!/bin/sh
# Build the knightCmd testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
  --top-module knightCmdTb -f files.f -o knightSim

./obj_dir/knightSim > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  exit 1
fi
